//--- branch_issue_top.f
+incdir+include
source/branch_pkg.sv
source/rob_window.sv
source/operand_file.sv
source/branch_buffer.sv
source/branch_resolver.sv
source/branch_issue_top.sv
test/branch_issue_tb.sv

//--- include/branch_unit_macros.svh
`ifndef BRANCH_UNIT_MACROS_SVH
`define BRANCH_UNIT_MACROS_SVH

// Reorder buffer slots. A power of two lets slot pointers wrap naturally.
`define ROB_LENGTH 16

// Width of PC values and branch targets.
`define PC_SIZE 16

// Physical data registers.
`define NUM_D_REG 32

// Physical status registers.
`define NUM_S_REG 8

// Entries in the waiting-branch buffer.
`define BB_LENGTH 4

`endif

//--- run.sh
#!/bin/sh
# Build and run the branch issue testbench; a failing run exits non-zero.
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module branch_issue_tb \
    -f branch_issue_top.f

./obj_dir/Vbranch_issue_tb

//--- source/branch_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "branch_unit_macros.svh"

module branch_buffer
    import branch_pkg::*;
#(
    parameter int L = `BB_LENGTH
)
(
    input  logic      clk,
    input  logic      n_rst,

    input  logic      in_valid,
    input  logic      reject,
    input  logic      retain,
    input  logic      restore,
    input  rob_addr_t restore_tail,
    input  rob_addr_t rob_head,

    input  rob_addr_t in_rob_addr,
    input  logic      in_jump,
    input  logic      in_predict_taken,
    input  pc_t       in_pc,
    input  pc_t       in_predict_target,
    input  d_tag_t    in_rt_addr,
    input  s_tag_t    in_rs_addr,

    input  logic      r_calculated_list [`NUM_D_REG],
    input  logic      s_calculated_list [`NUM_S_REG],

    output logic      full,
    output logic      issue_valid,
    output rob_addr_t issue_rob_addr,
    output logic      issue_jump,
    output logic      issue_predict_taken,
    output pc_t       issue_pc,
    output pc_t       issue_predict_target,
    output d_tag_t    issue_rt_addr,
    output s_tag_t    issue_rs_addr
);

    localparam int IW = (L > 1) ? $clog2(L) : 1;

    typedef struct packed {
        rob_addr_t rob_addr;
        logic      jump;
        logic      predict_taken;
        pc_t       pc;
        pc_t       predict_target;
        d_tag_t    rt_addr;
        s_tag_t    rs_addr;
    } bb_entry_t;

    bb_entry_t       entries [L];
    logic [L-1:0]    valid;
    logic [L-1:0]    entry_ready;
    logic            any_ready;
    logic [IW-1:0]   ready_addr;
    logic            any_open;
    logic [IW-1:0]   open_addr;
    logic            write_en;
    logic            take;

    // Slot is younger than the mispredicted branch when it falls outside [head, tail).
    function automatic logic in_window(input rob_addr_t addr, input rob_addr_t tail,
                                       input rob_addr_t head);
        if (tail > head) begin
            return (addr < tail) & (addr >= head);
        end
        return (addr < tail) | (addr >= head);
    endfunction

    always_comb begin
        for (int i = 0; i < L; i++) begin
            entry_ready[i] = valid[i] & r_calculated_list[entries[i].rt_addr]
                           & (entries[i].jump | s_calculated_list[entries[i].rs_addr]);
        end
    end

    // Downward scan, so the lowest index is picked.
    always_comb begin
        any_ready  = 1'b0;
        ready_addr = '0;
        any_open   = 1'b0;
        open_addr  = '0;
        for (int i = L - 1; i >= 0; i--) begin
            if (entry_ready[i]) begin
                any_ready  = 1'b1;
                ready_addr = IW'(i);
            end
            if (~valid[i]) begin
                any_open  = 1'b1;
                open_addr = IW'(i);
            end
        end
    end

    assign full = ~any_open;

    assign issue_valid = any_ready
                       & (~restore | in_window(entries[ready_addr].rob_addr, restore_tail,
                                               rob_head));
    assign issue_rob_addr       = entries[ready_addr].rob_addr;
    assign issue_jump           = entries[ready_addr].jump;
    assign issue_predict_taken  = entries[ready_addr].predict_taken;
    assign issue_pc             = entries[ready_addr].pc;
    assign issue_predict_target = entries[ready_addr].predict_target;
    assign issue_rt_addr        = entries[ready_addr].rt_addr;
    assign issue_rs_addr        = entries[ready_addr].rs_addr;

    assign write_en = in_valid & ~reject & any_open;
    assign take     = issue_valid & ~retain;

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            valid <= '0;
        end else begin
            // Younger entries go away on a mispredict.
            if (restore) begin
                for (int i = 0; i < L; i++) begin
                    if (~in_window(entries[i].rob_addr, restore_tail, rob_head)) begin
                        valid[i] <= 1'b0;
                    end
                end
            end
            if (take) begin
                valid[ready_addr] <= 1'b0;
            end
            // A branch arriving during a restore is itself younger.
            if (write_en) begin
                valid[open_addr] <= ~restore | in_window(in_rob_addr, restore_tail, rob_head);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            entries[open_addr] <= '{rob_addr: in_rob_addr, jump: in_jump,
                                    predict_taken: in_predict_taken, pc: in_pc,
                                    predict_target: in_predict_target,
                                    rt_addr: in_rt_addr, rs_addr: in_rs_addr};
        end
    end

endmodule

`default_nettype wire

//--- source/branch_issue_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "branch_unit_macros.svh"

module branch_issue_top
    import branch_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,

    input  logic      dispatch_valid,
    input  logic      dispatch_jump,
    input  logic      dispatch_predict_taken,
    input  pc_t       dispatch_pc,
    input  pc_t       dispatch_predict_target,
    input  d_tag_t    dispatch_rt_addr,
    input  s_tag_t    dispatch_rs_addr,
    output logic      full,

    input  logic      wb_d_valid,
    input  d_tag_t    wb_d_addr,
    input  pc_t       wb_d_data,
    input  logic      wb_s_valid,
    input  s_tag_t    wb_s_addr,
    input  logic      wb_s_data,

    input  logic      commit,
    output rob_addr_t rob_head,

    input  logic      result_ready,
    output logic      result_valid,
    output rob_addr_t result_rob_addr,
    output logic      result_mispredict,
    output pc_t       result_target
);

    rob_addr_t rob_tail;
    logic      rob_full;
    logic      bb_full;
    logic      accept;
    logic      retain;
    logic      restore;
    rob_addr_t restore_tail;
    logic      d_calculated [`NUM_D_REG];
    logic      s_calculated [`NUM_S_REG];
    pc_t       rt_value;
    logic      rs_value;
    logic      issue_valid;
    rob_addr_t issue_rob_addr;
    logic      issue_jump;
    logic      issue_predict_taken;
    pc_t       issue_pc;
    pc_t       issue_predict_target;
    d_tag_t    issue_rt_addr;
    s_tag_t    issue_rs_addr;

    assign full   = bb_full | rob_full;
    assign accept = dispatch_valid & ~full;

    rob_window u_rob (
        .clk, .n_rst,
        .alloc(accept), .commit, .restore, .restore_tail,
        .head(rob_head), .tail(rob_tail), .rob_full
    );

    // Dispatched sources wait for fresh writebacks.
    operand_file u_operands (
        .clk, .n_rst,
        .wb_d_valid, .wb_d_addr, .wb_d_data, .wb_s_valid, .wb_s_addr, .wb_s_data,
        .clear_d_valid(accept), .clear_d_addr(dispatch_rt_addr),
        .clear_s_valid(accept), .clear_s_addr(dispatch_rs_addr),
        .rd_rt_addr(issue_rt_addr), .rd_rs_addr(issue_rs_addr),
        .d_calculated, .s_calculated, .rt_value, .rs_value
    );

    branch_buffer #(.L(`BB_LENGTH)) u_buffer (
        .clk, .n_rst,
        .in_valid(dispatch_valid), .reject(rob_full), .retain, .restore, .restore_tail,
        .rob_head,
        .in_rob_addr(rob_tail), .in_jump(dispatch_jump),
        .in_predict_taken(dispatch_predict_taken), .in_pc(dispatch_pc),
        .in_predict_target(dispatch_predict_target),
        .in_rt_addr(dispatch_rt_addr), .in_rs_addr(dispatch_rs_addr),
        .r_calculated_list(d_calculated), .s_calculated_list(s_calculated),
        .full(bb_full), .issue_valid, .issue_rob_addr, .issue_jump, .issue_predict_taken,
        .issue_pc, .issue_predict_target, .issue_rt_addr, .issue_rs_addr
    );

    branch_resolver u_resolver (
        .clk, .n_rst,
        .issue_valid, .issue_rob_addr, .issue_jump, .issue_predict_taken, .issue_pc,
        .issue_predict_target, .rt_value, .rs_value, .result_ready,
        .retain, .restore, .restore_tail,
        .result_valid, .result_rob_addr, .result_mispredict, .result_target
    );

endmodule

`default_nettype wire

//--- source/branch_pkg.sv
`default_nettype none

`include "branch_unit_macros.svh"

package branch_pkg;

    // Index widths for the ROB and register files.
    localparam int ROB_ADDR_W = $clog2(`ROB_LENGTH);
    localparam int D_TAG_W    = $clog2(`NUM_D_REG);
    localparam int S_TAG_W    = $clog2(`NUM_S_REG);

    // Slot in the reorder buffer.
    typedef logic [ROB_ADDR_W-1:0] rob_addr_t;

    // PC value. Data register values share this width.
    typedef logic [`PC_SIZE-1:0] pc_t;

    // Physical data register index.
    typedef logic [D_TAG_W-1:0] d_tag_t;

    // Physical status register index.
    typedef logic [S_TAG_W-1:0] s_tag_t;

endpackage

`default_nettype wire

//--- source/branch_resolver.sv
`timescale 1ns/10ps
`default_nettype none

module branch_resolver
    import branch_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,

    input  logic      issue_valid,
    input  rob_addr_t issue_rob_addr,
    input  logic      issue_jump,
    input  logic      issue_predict_taken,
    input  pc_t       issue_pc,
    input  pc_t       issue_predict_target,

    input  pc_t       rt_value,
    input  logic      rs_value,
    input  logic      result_ready,

    output logic      retain,
    output logic      restore,
    output rob_addr_t restore_tail,
    output logic      result_valid,
    output rob_addr_t result_rob_addr,
    output logic      result_mispredict,
    output pc_t       result_target
);

    logic taken;
    pc_t  target;
    logic mispredict;
    logic load;
    logic restore_sent;

    // Jumps always go to rt. Branches test the status bit.
    assign taken      = issue_jump | rs_value;
    assign target     = taken ? rt_value : issue_pc + pc_t'(1);
    assign mispredict = (taken != issue_predict_taken)
                      | (taken & (target != issue_predict_target));

    // Result held while downstream stalls.
    assign retain = result_valid & ~result_ready;
    assign load   = issue_valid & ~retain;

    // Restore fires once, in the first cycle a mispredict is shown.
    assign restore      = result_valid & result_mispredict & ~restore_sent;
    assign restore_tail = result_rob_addr + rob_addr_t'(1);

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            result_valid <= 1'b0;
            restore_sent <= 1'b0;
        end else begin
            if (load) begin
                result_valid <= 1'b1;
                restore_sent <= 1'b0;
            end else begin
                if (result_ready) begin
                    result_valid <= 1'b0;
                end
                if (result_valid) begin
                    restore_sent <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            result_rob_addr   <= issue_rob_addr;
            result_mispredict <= mispredict;
            result_target     <= target;
        end
    end

endmodule

`default_nettype wire

//--- source/operand_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "branch_unit_macros.svh"

module operand_file
    import branch_pkg::*;
(
    input  logic   clk,
    input  logic   n_rst,

    input  logic   wb_d_valid,
    input  d_tag_t wb_d_addr,
    input  pc_t    wb_d_data,
    input  logic   wb_s_valid,
    input  s_tag_t wb_s_addr,
    input  logic   wb_s_data,

    input  logic   clear_d_valid,
    input  d_tag_t clear_d_addr,
    input  logic   clear_s_valid,
    input  s_tag_t clear_s_addr,

    input  d_tag_t rd_rt_addr,
    input  s_tag_t rd_rs_addr,

    output logic   d_calculated [`NUM_D_REG],
    output logic   s_calculated [`NUM_S_REG],
    output pc_t    rt_value,
    output logic   rs_value
);

    pc_t  d_value [`NUM_D_REG];
    logic s_value [`NUM_S_REG];

    // Calculated flags. A writeback beats a clear to the same register.
    always_ff @(posedge clk) begin
        if (~n_rst) begin
            d_calculated <= '{default: 1'b1};
            s_calculated <= '{default: 1'b1};
        end else begin
            if (clear_d_valid) begin
                d_calculated[clear_d_addr] <= 1'b0;
            end
            if (clear_s_valid) begin
                s_calculated[clear_s_addr] <= 1'b0;
            end
            if (wb_d_valid) begin
                d_calculated[wb_d_addr] <= 1'b1;
            end
            if (wb_s_valid) begin
                s_calculated[wb_s_addr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_d_valid) begin
            d_value[wb_d_addr] <= wb_d_data;
        end
        if (wb_s_valid) begin
            s_value[wb_s_addr] <= wb_s_data;
        end
    end

    // Read ports for the issuing branch.
    assign rt_value = d_value[rd_rt_addr];
    assign rs_value = s_value[rd_rs_addr];

endmodule

`default_nettype wire

//--- source/rob_window.sv
`timescale 1ns/10ps
`default_nettype none

`include "branch_unit_macros.svh"

module rob_window
    import branch_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,
    input  logic      alloc,
    input  logic      commit,
    input  logic      restore,
    input  rob_addr_t restore_tail,
    output rob_addr_t head,
    output rob_addr_t tail,
    output logic      rob_full
);

    localparam int CNT_W = $clog2(`ROB_LENGTH) + 1;

    logic [CNT_W-1:0] count;
    logic             do_commit;
    logic             do_alloc;
    rob_addr_t        next_head;
    rob_addr_t        restore_span;

    // Commit only retires an occupied slot.
    assign do_commit = commit & (count != '0);
    assign do_alloc  = alloc & ~rob_full;
    assign rob_full  = (count == CNT_W'(`ROB_LENGTH));

    assign next_head    = do_commit ? head + rob_addr_t'(1) : head;
    assign restore_span = restore_tail - next_head;

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head <= next_head;
            if (restore) begin
                // Slots after the mispredicted branch are dropped.
                tail <= restore_tail;
                // Branch is still in the ROB, so a zero span means every slot is in use.
                if (restore_span == '0) begin
                    count <= CNT_W'(`ROB_LENGTH);
                end else begin
                    count <= CNT_W'(restore_span);
                end
            end else begin
                if (do_alloc) begin
                    tail <= tail + rob_addr_t'(1);
                end
                count <= count + CNT_W'(do_alloc) - CNT_W'(do_commit);
            end
        end
    end

endmodule

`default_nettype wire

//--- test/branch_issue_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "branch_unit_macros.svh"

module branch_issue_tb
    import branch_pkg::*;
();

    localparam int NUM_ROWS = 12 + `BB_LENGTH;

    typedef struct packed {
        logic      jump;
        logic      pred_taken;
        pc_t       pc;
        pc_t       pred_target;
        d_tag_t    rt;
        s_tag_t    rs;
        pc_t       rt_val;
        logic      rs_val;
        logic      exp_mis;
        pc_t       exp_target;
        rob_addr_t rob;
    } row_t;

    logic      clk = 1'b0;
    logic      n_rst;
    logic      dispatch_valid;
    logic      dispatch_jump;
    logic      dispatch_predict_taken;
    pc_t       dispatch_pc;
    pc_t       dispatch_predict_target;
    d_tag_t    dispatch_rt_addr;
    s_tag_t    dispatch_rs_addr;
    logic      full;
    logic      wb_d_valid;
    d_tag_t    wb_d_addr;
    pc_t       wb_d_data;
    logic      wb_s_valid;
    s_tag_t    wb_s_addr;
    logic      wb_s_data;
    logic      commit;
    rob_addr_t rob_head;
    logic      result_ready;
    logic      result_valid;
    rob_addr_t result_rob_addr;
    logic      result_mispredict;
    pc_t       result_target;

    row_t      rows [NUM_ROWS];
    pc_t       rt_vals [NUM_ROWS];
    int        seed = 93152;
    rob_addr_t exp_tail = '0;
    rob_addr_t exp_head = '0;

    branch_issue_top u_dut (.*);

    always #10 clk = ~clk;

    initial begin
        repeat (NUM_ROWS * 40) @(posedge clk);
        $display("timeout: the DUT did not deliver all results in time");
        $display("RESULT: FAIL");
        $fatal(1);
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    function automatic pc_t row_pc(input int i);
        return pc_t'(32'h100 + 16 * i);
    endfunction

    task automatic add_row(input int i, input logic jump, input logic pred_taken,
                           input logic rs_val, input pc_t pred_target,
                           input logic exp_mis, input pc_t exp_target);
        rows[i].jump        = jump;
        rows[i].pred_taken  = pred_taken;
        rows[i].pc          = row_pc(i);
        rows[i].pred_target = pred_target;
        rows[i].rt          = d_tag_t'(i + 1);
        rows[i].rs          = s_tag_t'(i);
        rows[i].rt_val      = rt_vals[i];
        rows[i].rs_val      = rs_val;
        rows[i].exp_mis     = exp_mis;
        rows[i].exp_target  = exp_target;
        rows[i].rob         = '0;
    endtask

    // Jumps and taken branches go to rt. Not-taken branches go to pc+1.
    task automatic load_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            rt_vals[i] = pc_t'($random(seed));
        end
        add_row(0, 1'b1, 1'b1, 1'b0, rt_vals[0], 1'b0, rt_vals[0]);
        add_row(1, 1'b0, 1'b1, 1'b1, rt_vals[1], 1'b0, rt_vals[1]);
        add_row(2, 1'b0, 1'b0, 1'b0, rt_vals[2], 1'b0, row_pc(2) + pc_t'(1));
        add_row(3, 1'b0, 1'b1, 1'b0, rt_vals[3], 1'b1, row_pc(3) + pc_t'(1));
        add_row(4, 1'b1, 1'b1, 1'b0, rt_vals[4] ^ pc_t'(1), 1'b1, rt_vals[4]);
        add_row(5, 1'b0, 1'b0, 1'b1, rt_vals[5], 1'b1, rt_vals[5]);
        add_row(6, 1'b1, 1'b1, 1'b0, rt_vals[6], 1'b0, rt_vals[6]);
        add_row(7, 1'b0, 1'b1, 1'b1, rt_vals[7], 1'b0, rt_vals[7]);
        add_row(8, 1'b0, 1'b1, 1'b0, rt_vals[8], 1'b1, row_pc(8) + pc_t'(1));
        add_row(9, 1'b0, 1'b1, 1'b1, rt_vals[9], 1'b0, rt_vals[9]);
        for (int i = 10; i < NUM_ROWS; i++) begin
            add_row(i, 1'b1, 1'b1, 1'b0, rt_vals[i], 1'b0, rt_vals[i]);
        end
    endtask

    task automatic after_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_fields(input int i);
        dispatch_valid          = 1'b1;
        dispatch_jump           = rows[i].jump;
        dispatch_predict_taken  = rows[i].pred_taken;
        dispatch_pc             = rows[i].pc;
        dispatch_predict_target = rows[i].pred_target;
        dispatch_rt_addr        = rows[i].rt;
        dispatch_rs_addr        = rows[i].rs;
    endtask

    // Holds the request until the buffer has room.
    task automatic dispatch(input int i);
        after_edge();
        drive_fields(i);
        @(negedge clk);
        while (full) @(negedge clk);
        after_edge();
        dispatch_valid = 1'b0;
        rows[i].rob = exp_tail;
        exp_tail++;
    endtask

    // Odd branch rows write the status register first.
    task automatic write_operands(input int i);
        logic status_first;
        status_first = !rows[i].jump && (i % 2 == 1);
        after_edge();
        wb_d_valid = !status_first;
        wb_s_valid = status_first;
        wb_d_addr  = rows[i].rt;
        wb_d_data  = rows[i].rt_val;
        wb_s_addr  = rows[i].rs;
        wb_s_data  = rows[i].rs_val;
        if (!rows[i].jump) begin
            after_edge();
            wb_d_valid = status_first;
            wb_s_valid = !status_first;
        end
        after_edge();
        wb_d_valid = 1'b0;
        wb_s_valid = 1'b0;
    endtask

    task automatic check_result(input int i);
        check_value(32'(result_valid), 1, "result_valid");
        check_value(32'(result_rob_addr), 32'(rows[i].rob), "result_rob_addr");
        check_value(32'(result_mispredict), 32'(rows[i].exp_mis), "result_mispredict");
        check_value(32'(result_target), 32'(rows[i].exp_target), "result_target");
    endtask

    task automatic commit_one();
        after_edge();
        commit = 1'b1;
        after_edge();
        commit = 1'b0;
        exp_head++;
        @(negedge clk);
        check_value(32'(rob_head), 32'(exp_head), "rob_head after commit");
    endtask

    task automatic resolve(input int i);
        write_operands(i);
        @(negedge clk);
        check_value(32'(result_valid), 0, "result_valid before last operand");
        while (!result_valid) @(negedge clk);
        check_result(i);
        // A mispredict pulls the tail back behind the branch.
        if (rows[i].exp_mis) begin
            exp_tail = rows[i].rob + rob_addr_t'(1);
        end
        commit_one();
    endtask

    initial begin
        n_rst                   = 1'b0;
        dispatch_valid          = 1'b0;
        dispatch_jump           = 1'b0;
        dispatch_predict_taken  = 1'b0;
        dispatch_pc             = '0;
        dispatch_predict_target = '0;
        dispatch_rt_addr        = '0;
        dispatch_rs_addr        = '0;
        wb_d_valid              = 1'b0;
        wb_d_addr               = '0;
        wb_d_data               = '0;
        wb_s_valid              = 1'b0;
        wb_s_addr               = '0;
        wb_s_data               = 1'b0;
        commit                  = 1'b0;
        result_ready            = 1'b1;
        load_table();
        repeat (3) @(posedge clk);
        #1;
        n_rst = 1'b1;
        @(negedge clk);
        check_value(32'(full), 0, "full after reset");
        check_value(32'(result_valid), 0, "result_valid after reset");
        check_value(32'(rob_head), 0, "rob_head after reset");

        for (int i = 0; i < 6; i++) begin
            dispatch(i);
            resolve(i);
        end

        // Stalled result holds while a second branch waits.
        after_edge();
        result_ready = 1'b0;
        dispatch(6);
        dispatch(7);
        write_operands(6);
        while (!result_valid) @(negedge clk);
        check_result(6);
        write_operands(7);
        repeat (3) begin
            @(negedge clk);
            check_result(6);
        end
        after_edge();
        result_ready = 1'b1;
        @(negedge clk);
        check_result(6);
        @(negedge clk);
        check_result(7);
        commit_one();
        commit_one();

        // Younger branch is flushed by the older mispredict.
        dispatch(8);
        dispatch(9);
        resolve(8);
        write_operands(9);
        repeat (4) begin
            @(negedge clk);
            check_value(32'(result_valid), 0, "result_valid for flushed branch");
        end
        dispatch(10);
        resolve(10);

        for (int k = 0; k < `BB_LENGTH; k++) begin
            dispatch(11 + k);
        end
        @(negedge clk);
        check_value(32'(full), 1, "full with buffer filled");
        after_edge();
        drive_fields(NUM_ROWS - 1);
        repeat (2) begin
            @(negedge clk);
            check_value(32'(full), 1, "full while dispatch blocked");
        end
        write_operands(11);
        @(negedge clk);
        check_value(32'(full), 1, "full before issue");
        @(negedge clk);
        check_value(32'(full), 0, "full after issue");
        check_result(11);
        after_edge();
        dispatch_valid = 1'b0;
        rows[NUM_ROWS - 1].rob = exp_tail;
        exp_tail++;
        commit_one();
        for (int i = 12; i < NUM_ROWS; i++) begin
            resolve(i);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
